/* list.f */
common/soc_pkg.sv
common/periph_bus_if.sv
uart/uart_tx.sv
uart/uart_rx.sv
design/bus_decoder.sv
design/soc_ram.sv
uart/peripheral_uart.sv
mult/peripheral_mult.sv
design/soc_top.sv
sim/tb_soc.sv

/* Bender.yml */
package:
  name: soc_periph

sources:
  - common/soc_pkg.sv
  - common/periph_bus_if.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - design/bus_decoder.sv
  - design/soc_ram.sv
  - uart/peripheral_uart.sv
  - mult/peripheral_mult.sv
  - design/soc_top.sv
  - target: simulation
    files:
      - sim/tb_soc.sv

/* sim/tb_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
  import soc_pkg::*;

  localparam int CLK_PERIOD = 20;
  // 50 MHz over 3.125 Mbaud gives 16 clocks per bit
  localparam int TB_BAUD = DEF_CLK_FREQ / 16;
  localparam int N_RAM = 40;
  localparam int N_MULT = 8;
  localparam int N_UART = 6;
  localparam int POLL_LIMIT = 400;
  // frame time per byte, loop costs, then slack
  localparam int WATCHDOG_CYCLES = N_UART * 10 * 16 + N_RAM * 8 + N_MULT * 32 + 2000;

  logic clk;
  logic rst_n;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wmask;
  logic mem_rstrb;
  logic [31:0] mem_rdata;
  logic rxd;
  logic txd;
  logic [0:0] leds;

  // word captured by the last bus_read
  logic [31:0] rd_val;
  integer seed;
  logic [31:0] r;
  logic [31:0] ram_ref [RAM_WORDS];
  bit ram_init [RAM_WORDS];

  soc_top #(
    .clk_freq(DEF_CLK_FREQ),
    .baud    (TB_BAUD)
  ) i_soc_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask),
    .mem_rstrb(mem_rstrb),
    .mem_rdata(mem_rdata),
    .rxd      (rxd),
    .txd      (txd),
    .leds     (leds)
  );

  // serial loopback
  assign rxd = txd;

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h",
                                  name, expected, actual));
    end
  endtask

  // called on a falling edge, the write lands on the next rising edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    mem_addr = addr;
    mem_wdata = data;
    mem_wmask = mask;
    @(negedge clk);
    mem_wmask = 4'h0;
  endtask

  // strobe for one cycle, data valid one cycle later
  task automatic bus_read(input logic [31:0] addr);
    mem_addr = addr;
    mem_rstrb = 1'b1;
    @(negedge clk);
    mem_rstrb = 1'b0;
    rd_val = mem_rdata;
  endtask

  // read until the bit takes the value, rd_val keeps the last status
  task automatic poll_status(input logic [31:0] addr, input int bit_idx,
                             input logic value, input string what);
    int polls;
    polls = 0;
    bus_read(addr);
    while (rd_val[bit_idx] !== value) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_with_failure($sformatf("%s not seen within %0d status polls", what, POLL_LIMIT));
      end
      bus_read(addr);
    end
  endtask

  function automatic logic [31:0] uart_addr(input logic [REG_AW-1:0] off);
    return {REGION_UART, 11'b0, off};
  endfunction

  function automatic logic [31:0] mult_addr(input logic [REG_AW-1:0] off);
    return {REGION_MULT, 11'b0, off};
  endfunction

  // reference model, one byte lane per mask bit
  task automatic merge_ram_ref(input logic [RAM_AW-1:0] idx, input logic [31:0] data,
                               input logic [3:0] mask);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        ram_ref[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  // read data stays defined once out of reset
  a_rdata_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(mem_rdata)
  ) else stop_with_failure("mem_rdata became unknown after reset");

  a_txd_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(txd)
  ) else stop_with_failure("txd became unknown after reset");

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    logic [RAM_AW-1:0] idx;
    logic [31:0] wdata;
    logic [3:0] mask;
    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [7:0] tx_byte;

    rst_n = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wmask = '0;
    mem_rstrb = 1'b0;
    seed = 32'ha3a2;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // reset state
    check_value("txd", 32'h1, {31'h0, txd});
    check_value("leds", 32'h0, {31'h0, leds});
    check_value("mem_rdata", BUS_UNMAPPED, mem_rdata);
    bus_read(uart_addr(UART_STATUS));
    check_value("uart status", 32'h0, rd_val);
    bus_read(mult_addr(MULT_STATUS));
    check_value("mult status", 32'h0, rd_val);

    // ram byte masks, a full word first so no lane is unknown
    for (int n = 0; n < N_RAM; n++) begin
      r = $random(seed);
      idx = r[RAM_AW-1:0];
      if (!ram_init[idx]) begin
        wdata = $random(seed);
        bus_write({20'h0, idx, 2'b00}, wdata, 4'hf);
        ram_ref[idx] = wdata;
        ram_init[idx] = 1'b1;
      end
      wdata = $random(seed);
      r = $random(seed);
      mask = r[3:0];
      bus_write({20'h0, idx, 2'b00}, wdata, mask);
      merge_ram_ref(idx, wdata, mask);
      bus_read({20'h0, idx, 2'b00});
      check_value("mem_rdata", ram_ref[idx], rd_val);
    end

    // unmapped region 0x0041 lands in ram, and 4 KiB aliases wrap
    wdata = $random(seed);
    bus_write(32'h0041_0010, wdata, 4'hf);
    bus_read(32'h0000_0010);
    check_value("mem_rdata", wdata, rd_val);
    bus_read(32'h0000_1010);
    check_value("mem_rdata", wdata, rd_val);

    // multiplier, corner case first
    for (int n = 0; n < N_MULT; n++) begin
      r = $random(seed);
      op_a = (n == 0) ? 16'hffff : r[15:0];
      op_b = (n == 0) ? 16'hffff : r[31:16];
      bus_write(mult_addr(MULT_A), {16'h0, op_a}, 4'hf);
      bus_write(mult_addr(MULT_B), {16'h0, op_b}, 4'hf);
      // start lands on edge 0
      bus_write(mult_addr(MULT_START), 32'h1, 4'hf);
      bus_read(mult_addr(MULT_STATUS));
      check_value("mult done", 32'h0, rd_val & 32'h1);
      repeat (14) @(negedge clk);
      // strobe on edge 16 still sees the old done
      bus_read(mult_addr(MULT_STATUS));
      check_value("mult done", 32'h0, rd_val & 32'h1);
      bus_read(mult_addr(MULT_STATUS));
      check_value("mult done", 32'h1, rd_val & 32'h1);
      bus_read(mult_addr(MULT_RESULT));
      check_value("mult result", 32'(op_a) * 32'(op_b), rd_val);
    end

    // uart loopback
    for (int n = 0; n < N_UART; n++) begin
      r = $random(seed);
      tx_byte = r[7:0];
      bus_write(uart_addr(UART_TXDATA), {24'h0, tx_byte}, 4'h1);
      bus_read(uart_addr(UART_STATUS));
      check_value("uart busy", 32'h1, rd_val & 32'h1);
      // dropped, the line is mid frame
      bus_write(uart_addr(UART_TXDATA), {24'h0, ~tx_byte}, 4'h1);
      poll_status(uart_addr(UART_STATUS), 1, 1'b1, "uart rx valid");
      bus_read(uart_addr(UART_RXDATA));
      check_value("uart rxdata", {24'h0, tx_byte}, rd_val);
      bus_read(uart_addr(UART_STATUS));
      check_value("uart rx valid", 32'h0, rd_val & 32'h2);
      // no second frame may follow
      poll_status(uart_addr(UART_STATUS), 0, 1'b0, "uart tx idle");
      check_value("uart status", 32'h0, rd_val);
    end

    // led register
    bus_write(uart_addr(UART_LED), 32'h1, 4'hf);
    check_value("leds", 32'h1, {31'h0, leds});
    bus_read(uart_addr(UART_LED));
    check_value("uart led", 32'h1, rd_val);
    bus_write(uart_addr(UART_LED), 32'h0, 4'hf);
    check_value("leds", 32'h0, {31'h0, leds});
    bus_read(uart_addr(UART_LED));
    check_value("uart led", 32'h0, rd_val);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned clk_freq = soc_pkg::DEF_CLK_FREQ,
  parameter int unsigned baud     = soc_pkg::DEF_BAUD
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wmask,
  input  logic        mem_rstrb,
  output logic [31:0] mem_rdata,
  input  logic        rxd,
  output logic        txd,
  output logic [0:0]  leds
);
  import soc_pkg::*;

  logic [CS_W-1:0] cs;
  logic [31:0] ram_rdata;
  logic [31:0] uart_rdata;
  logic [31:0] mult_rdata;

  periph_bus_if bus ();

  // cpu side ports onto the shared bus
  assign bus.addr = mem_addr[REG_AW-1:0];
  assign bus.full_addr = mem_addr;
  assign bus.wdata = mem_wdata;
  assign bus.wmask = mem_wmask;
  assign bus.rd = mem_rstrb;
  // any mask lane means a write
  assign bus.wr = |mem_wmask;

  bus_decoder i_bus_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .cs        (cs),
    .ram_rdata (ram_rdata),
    .uart_rdata(uart_rdata),
    .mult_rdata(mult_rdata),
    .mem_rdata (mem_rdata)
  );

  soc_ram i_soc_ram (
    .clk  (clk),
    .bus  (bus),
    .cs   (cs[CS_RAM]),
    .rdata(ram_rdata)
  );

  peripheral_uart #(
    .clk_freq(clk_freq),
    .baud    (baud)
  ) i_peripheral_uart (
    .clk  (clk),
    .rst_n(rst_n),
    .bus  (bus),
    .cs   (cs[CS_UART]),
    .rdata(uart_rdata),
    .rxd  (rxd),
    .txd  (txd),
    .led  (leds[0])
  );

  peripheral_mult i_peripheral_mult (
    .clk  (clk),
    .rst_n(rst_n),
    .bus  (bus),
    .cs   (cs[CS_MULT]),
    .rdata(mult_rdata)
  );

endmodule

`default_nettype wire

/* mult/peripheral_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module peripheral_mult (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.target bus,
  input  logic         cs,
  output logic [31:0]  rdata
);
  import soc_pkg::*;

  logic [15:0] a_q;
  logic [15:0] b_q;
  // upper half sums, lower half holds the remaining multiplier bits
  logic [31:0] acc_q;
  logic [4:0] step_q;
  logic busy_q;
  logic done_q;
  logic start;
  logic [16:0] sum;

  assign start = cs && bus.wr && (bus.addr == MULT_START) && !busy_q;
  assign sum = {1'b0, acc_q[31:16]} + (acc_q[0] ? {1'b0, a_q} : 17'd0);

  // start at edge 0, steps on edges 1..16, done with the last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (busy_q) begin
      step_q <= step_q + 5'd1;
      if (step_q == 5'd15) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // operands frozen while a product is running
  always_ff @(posedge clk) begin
    if (cs && bus.wr && !busy_q) begin
      if (bus.addr == MULT_A) begin
        a_q <= bus.wdata[15:0];
      end
      if (bus.addr == MULT_B) begin
        b_q <= bus.wdata[15:0];
      end
    end
  end

  // shift-add, one multiplier bit per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      acc_q <= {16'b0, b_q};
    end else if (busy_q) begin
      acc_q <= {sum, acc_q[15:1]};
    end
  end

  // status is {busy, done}
  always_ff @(posedge clk) begin
    if (cs && bus.rd) begin
      case (bus.addr)
        MULT_A:      rdata <= {16'b0, a_q};
        MULT_B:      rdata <= {16'b0, b_q};
        MULT_STATUS: rdata <= {30'b0, busy_q, done_q};
        MULT_RESULT: rdata <= acc_q;
        default:     rdata <= 32'b0;
      endcase
    end
  end

  a_step_range: assert property (
    @(posedge clk) disable iff (!rst_n) step_q <= 5'd16
  ) else $error("peripheral_mult: step counter out of range: %0d", step_q);

endmodule

`default_nettype wire

/* uart/peripheral_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module peripheral_uart #(
  parameter int unsigned clk_freq = soc_pkg::DEF_CLK_FREQ,
  parameter int unsigned baud     = soc_pkg::DEF_BAUD
) (
  input  logic         clk,
  input  logic         rst_n,
  periph_bus_if.target bus,
  input  logic         cs,
  output logic [31:0]  rdata,
  input  logic         rxd,
  output logic         txd,
  output logic         led
);
  import soc_pkg::*;

  logic tx_start;
  logic tx_busy;
  logic [7:0] rx_byte;
  logic rx_done;
  logic [7:0] rx_data_q;
  logic rx_valid_q;
  logic led_q;
  logic rd_rxdata;

  // new frame only when the transmitter is free
  assign tx_start = cs && bus.wr && (bus.addr == UART_TXDATA) && !tx_busy;
  assign rd_rxdata = cs && bus.rd && (bus.addr == UART_RXDATA);
  assign led = led_q;

  uart_tx #(
    .clks_per_bit(clk_freq / baud)
  ) i_uart_tx (
    .clk  (clk),
    .rst_n(rst_n),
    .start(tx_start),
    .data (bus.wdata[7:0]),
    .busy (tx_busy),
    .txd  (txd)
  );

  uart_rx #(
    .clks_per_bit(clk_freq / baud)
  ) i_uart_rx (
    .clk  (clk),
    .rst_n(rst_n),
    .rxd  (rxd),
    .data (rx_byte),
    .done (rx_done)
  );

  // receive holding register, a new frame wins over the read clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid_q <= 1'b0;
      led_q <= 1'b0;
    end else begin
      if (rx_done) begin
        rx_valid_q <= 1'b1;
      end else if (rd_rxdata) begin
        rx_valid_q <= 1'b0;
      end
      if (cs && bus.wr && (bus.addr == UART_LED)) begin
        led_q <= bus.wdata[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_done) begin
      rx_data_q <= rx_byte;
    end
  end

  // register read, status is {rx valid, tx busy}
  always_ff @(posedge clk) begin
    if (cs && bus.rd) begin
      case (bus.addr)
        UART_STATUS: rdata <= {30'b0, rx_valid_q, tx_busy};
        UART_RXDATA: rdata <= {24'b0, rx_data_q};
        UART_LED:    rdata <= {31'b0, led_q};
        default:     rdata <= 32'b0;
      endcase
    end
  end

  // a start is accepted by an idle transmitter and makes it busy
  a_tx_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy ##1 tx_busy
  ) else $error("peripheral_uart: transmit start not taken by an idle transmitter");

endmodule

`default_nettype wire

/* design/soc_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_ram (
  input  logic         clk,
  periph_bus_if.target bus,
  input  logic         cs,
  output logic [31:0]  rdata
);
  import soc_pkg::*;

  logic [31:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;

  // byte address to word index, upper bits dropped so it wraps
  assign word_idx = bus.full_addr[RAM_AW+1:2];

  // write, one lane per mask bit
  always_ff @(posedge clk) begin
    if (cs && bus.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wmask[i]) begin
          mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, held until the next selected read
  always_ff @(posedge clk) begin
    if (cs && bus.rd) begin
      rdata <= mem[word_idx];
    end
  end

  // master never reads and writes in one cycle
  a_no_rd_wr: assert property (
    @(posedge clk) !(bus.rd && bus.wr)
  ) else $error("soc_ram: read and write strobes high together");

endmodule

`default_nettype wire

/* design/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                     clk,
  input  logic                     rst_n,
  periph_bus_if.target             bus,
  output logic [soc_pkg::CS_W-1:0] cs,
  input  logic [31:0]              ram_rdata,
  input  logic [31:0]              uart_rdata,
  input  logic [31:0]              mult_rdata,
  output logic [31:0]              mem_rdata
);
  import soc_pkg::*;

  // select of the last read, zero until the first one
  logic [CS_W-1:0] sel_q;

  // region decode, anything unknown falls to ram
  always_comb begin
    cs = '0;
    case (bus.full_addr[31:32-ADDR_REGION_W])
      REGION_UART: cs[CS_UART] = 1'b1;
      REGION_MULT: cs[CS_MULT] = 1'b1;
      default:     cs[CS_RAM] = 1'b1;
    endcase
  end

  // blocks register their word on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else if (bus.rd) begin
      sel_q <= cs;
    end
  end

  // read mux keyed by the latched select
  always_comb begin
    if (sel_q[CS_RAM]) begin
      mem_rdata = ram_rdata;
    end else if (sel_q[CS_UART]) begin
      mem_rdata = uart_rdata;
    end else if (sel_q[CS_MULT]) begin
      mem_rdata = mult_rdata;
    end else begin
      mem_rdata = BUS_UNMAPPED;
    end
  end

  // exactly one block owns every address
  a_cs_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot(cs)
  ) else $error("bus_decoder: chip select not one-hot: %b", cs);

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned clks_per_bit = soc_pkg::DEF_CLK_FREQ / soc_pkg::DEF_BAUD
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic [7:0] data,
  output logic       done
);
  localparam int unsigned CNT_W = $clog2(clks_per_bit + 1);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(clks_per_bit - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(clks_per_bit / 2);

  // two-flop synchronizer, idles high
  logic [1:0] sync_q;
  logic rxd_s;
  logic active_q;
  logic [CNT_W-1:0] cnt_q;
  // 0 start check, 1..8 data, 9 stop
  logic [3:0] bit_q;

  assign rxd_s = sync_q[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rxd};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      cnt_q <= '0;
      bit_q <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!active_q) begin
        cnt_q <= '0;
        bit_q <= '0;
        // falling edge opens a frame
        if (!rxd_s) begin
          active_q <= 1'b1;
        end
      end else if (bit_q == 4'd0) begin
        if (cnt_q == HALF) begin
          cnt_q <= '0;
          // still low at mid start bit, else a glitch
          if (rxd_s) begin
            active_q <= 1'b0;
          end else begin
            bit_q <= 4'd1;
          end
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (cnt_q == BIT_END) begin
        cnt_q <= '0;
        if (bit_q == 4'd9) begin
          active_q <= 1'b0;
          // bad stop bit drops the frame
          done <= rxd_s;
        end else begin
          bit_q <= bit_q + 4'd1;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // data bits sampled mid-period, lsb arrives first
  always_ff @(posedge clk) begin
    if (active_q && (bit_q != 4'd0) && (bit_q != 4'd9) && (cnt_q == BIT_END)) begin
      data <= {rxd_s, data[7:1]};
    end
  end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned clks_per_bit = soc_pkg::DEF_CLK_FREQ / soc_pkg::DEF_BAUD
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       txd
);
  localparam int unsigned CNT_W = $clog2(clks_per_bit + 1);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(clks_per_bit - 1);

  // remaining bits, stop bit on top
  logic [8:0] shift_q;
  logic [CNT_W-1:0] cnt_q;
  // 0 start, 1..8 data, 9 stop
  logic [3:0] bit_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      txd <= 1'b1;
      cnt_q <= '0;
      bit_q <= '0;
    end else if (!busy) begin
      cnt_q <= '0;
      bit_q <= '0;
      if (start) begin
        busy <= 1'b1;
        // start bit goes out at once
        txd <= 1'b0;
      end
    end else if (cnt_q == BIT_END) begin
      cnt_q <= '0;
      if (bit_q == 4'd9) begin
        // stop bit done, line already high
        busy <= 1'b0;
      end else begin
        bit_q <= bit_q + 4'd1;
        txd <= shift_q[0];
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // lsb first, ones shifted in behind
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shift_q <= {1'b1, data};
    end else if (busy && (cnt_q == BIT_END) && (bit_q != 4'd9)) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

`default_nettype wire

/* common/periph_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
  import soc_pkg::*;

  // register offset for the peripherals
  logic [REG_AW-1:0] addr;
  // whole address, decoder and ram
  logic [31:0] full_addr;
  logic [31:0] wdata;
  logic [3:0] wmask;
  // single-cycle strobes
  logic rd;
  logic wr;

  modport source (output addr, output full_addr, output wdata, output wmask, output rd, output wr);
  modport target (input addr, input full_addr, input wdata, input wmask, input rd, input wr);

endinterface

`default_nettype wire

/* common/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // word ram, 4 KiB
  localparam int unsigned RAM_WORDS = 1024;
  localparam int unsigned RAM_AW = 10;

  // region field is mem_addr[31:16]
  localparam int unsigned ADDR_REGION_W = 16;
  localparam logic [ADDR_REGION_W-1:0] REGION_UART = 16'h0040;
  localparam logic [ADDR_REGION_W-1:0] REGION_MULT = 16'h0042;

  // chip select bit positions
  localparam int unsigned CS_W = 3;
  localparam int unsigned CS_RAM = 0;
  localparam int unsigned CS_UART = 1;
  localparam int unsigned CS_MULT = 2;

  // peripheral register offset width, mem_addr[4:0]
  localparam int unsigned REG_AW = 5;

  // uart register map
  localparam logic [REG_AW-1:0] UART_STATUS = 5'h00;
  localparam logic [REG_AW-1:0] UART_TXDATA = 5'h04;
  localparam logic [REG_AW-1:0] UART_RXDATA = 5'h08;
  localparam logic [REG_AW-1:0] UART_LED = 5'h0C;

  // multiplier register map
  localparam logic [REG_AW-1:0] MULT_A = 5'h00;
  localparam logic [REG_AW-1:0] MULT_B = 5'h04;
  localparam logic [REG_AW-1:0] MULT_START = 5'h08;
  localparam logic [REG_AW-1:0] MULT_STATUS = 5'h0C;
  localparam logic [REG_AW-1:0] MULT_RESULT = 5'h10;

  // default serial timing
  localparam int unsigned DEF_CLK_FREQ = 50_000_000;
  localparam int unsigned DEF_BAUD = 9600;

  // read data before any select has been latched
  localparam logic [31:0] BUS_UNMAPPED = 32'h6666_6666;

endpackage

`default_nettype wire
